/* src/recorder_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Shared widths, port map and types for the message controller
////////////////////////////////////////////////////////////////////////////

package recorder_pkg;

	// Bus and word widths
	localparam int ADDR_W = 26;
	localparam int DATA_W = 16;
	localparam int PORT_W = 8;

	// Slot index type
	typedef logic [2:0] slot_t;

	// Slot map of the word memory
	localparam int SLOT_COUNT = 5;
	localparam logic [ADDR_W-1:0] SLOT_WORDS = 26'h333333;
	// Top slot runs up to the memory size input
	localparam slot_t LAST_SLOT = slot_t'(SLOT_COUNT - 1);

	// Ports written by the processor
	localparam logic [PORT_W-1:0] PORT_MODE = 8'h0B;
	localparam logic [PORT_W-1:0] PORT_SLOT = 8'h0C;
	localparam logic [PORT_W-1:0] PORT_RECORD = 8'h05;
	localparam logic [PORT_W-1:0] PORT_VOLUME = 8'h04;

	// Ports read by the processor
	localparam logic [PORT_W-1:0] PORT_SELECT = 8'h08;
	localparam logic [PORT_W-1:0] PORT_BACK = 8'h09;
	localparam logic [PORT_W-1:0] PORT_PAUSE = 8'h0A;
	localparam logic [PORT_W-1:0] PORT_MSG_EXISTS = 8'h0B;
	localparam logic [PORT_W-1:0] PORT_DEL_DONE = 8'h0F;

	// Volume range
	localparam int VOL_W = 4;
	localparam logic [VOL_W-1:0] VOL_MIN = 4'd1;
	localparam logic [VOL_W-1:0] VOL_MAX = 4'd15;

	// Menu mode as written to the mode port
	typedef enum logic [2:0] {
		MODE_MAIN = 3'd0,
		MODE_PLAY = 3'd1,
		MODE_RECORD = 3'd2,
		MODE_DELETE_ONE = 3'd3,
		MODE_DELETE_ALL = 3'd4,
		MODE_VOLUME = 3'd5
	} menu_mode_e;

	// Sequencer states
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_PLAY_WAIT,
		ST_PLAY_REQUEST,
		ST_PLAY_FETCH,
		ST_PLAY_STEP,
		ST_RECORD_CHECK,
		ST_RECORD_PROBE,
		ST_RECORD_WRITE,
		ST_RECORD_STEP,
		ST_DELETE_WRITE,
		ST_DELETE_STEP
	} seq_state_e;

endpackage

`default_nettype wire

/* src/menu_if.sv */
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Menu state between port registers and the message sequencer
////////////////////////////////////////////////////////////////////////////

interface menu_if import recorder_pkg::*; ();

	// Current menu mode
	menu_mode_e mode;
	// One cycle pulse per mode port write
	logic mode_write;
	// Chosen message slot
	slot_t slot;
	// Slot chosen since the last mode write
	logic slot_valid;
	// Record start request
	logic record_armed;

	// Status back from the sequencer
	logic message_exists;
	logic delete_finish;

	// Register block side
	modport regs (
		output mode,
		output mode_write,
		output slot,
		output slot_valid,
		output record_armed,
		input message_exists,
		input delete_finish
	);

	// Sequencer side
	modport seq (
		input mode,
		input mode_write,
		input slot,
		input slot_valid,
		input record_armed,
		output message_exists,
		output delete_finish
	);

endinterface

`default_nettype wire

/* src/walker_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Address walker control and result
interface walker_if import recorder_pkg::*; ();

	// Load pulses and the slot to load
	logic load_slot;
	logic load_all;
	slot_t slot;
	// Advance by one word
	logic step;

	// Current memory address
	logic [ADDR_W-1:0] address;
	// At or past the walk limit
	logic last;

	modport seq (
		output load_slot,
		output load_all,
		output slot,
		output step,
		input address,
		input last
	);

	modport walker (
		input load_slot,
		input load_all,
		input slot,
		input step,
		output address,
		output last
	);

endinterface

`default_nettype wire

/* src/pb_port_regs.sv */
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Processor port decode, menu registers and volume
////////////////////////////////////////////////////////////////////////////

module pb_port_regs import recorder_pkg::*; (
	input wire clk2,
	input wire pb_reset,
	input wire [PORT_W-1:0] port_id,
	input wire [PORT_W-1:0] out_port,
	input wire write_strobe,
	input wire select,
	input wire back,
	input wire pause_play,
	output logic [PORT_W-1:0] in_port,
	output logic [VOL_W-1:0] volume,
	menu_if.regs menu
);

	// Write decode per port
	logic wr_mode;
	logic wr_slot;
	logic wr_record;
	logic wr_volume;
	// Mode value with unknown codes folded to main
	menu_mode_e new_mode;

	assign wr_mode = write_strobe && (port_id == PORT_MODE);
	assign wr_slot = write_strobe && (port_id == PORT_SLOT);
	assign wr_record = write_strobe && (port_id == PORT_RECORD);
	assign wr_volume = write_strobe && (port_id == PORT_VOLUME);

	assign new_mode = (out_port <= PORT_W'(MODE_VOLUME)) ?
		menu_mode_e'(out_port[2:0]) : MODE_MAIN;

	////////////////////////////////////////////////////////////////////////
	// Menu registers
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			menu.mode <= MODE_MAIN;
			menu.mode_write <= 1'b0;
			menu.slot <= '0;
			menu.slot_valid <= 1'b0;
			menu.record_armed <= 1'b0;
		end else begin
			menu.mode_write <= wr_mode;
			// New mode drops any slot choice and arm
			if (wr_mode) begin
				menu.mode <= new_mode;
				menu.slot_valid <= 1'b0;
				menu.record_armed <= 1'b0;
			end
			// Slot choice for play and single delete
			if (wr_slot && (menu.mode == MODE_PLAY || menu.mode == MODE_DELETE_ONE)
					&& out_port < PORT_W'(SLOT_COUNT)) begin
				menu.slot <= slot_t'(out_port);
				menu.slot_valid <= 1'b1;
			end
			// Record port carries arm, disarm and slot codes
			if (wr_record && menu.mode == MODE_RECORD) begin
				if (out_port == PORT_W'(0)) begin
					menu.record_armed <= 1'b0;
				end else if (out_port == PORT_W'(1)) begin
					menu.record_armed <= 1'b1;
				end else if (out_port < PORT_W'(SLOT_COUNT + 2)) begin
					// Codes 2 up select slot code minus two
					menu.slot <= slot_t'(out_port - PORT_W'(2));
					menu.slot_valid <= 1'b1;
					menu.record_armed <= 1'b0;
				end
			end
		end
	end

	// Volume steps once per write, saturating both ways
	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			volume <= VOL_MIN;
		end else if (wr_volume && menu.mode == MODE_VOLUME) begin
			if (out_port == PORT_W'(1) && volume < VOL_MAX) begin
				volume <= volume + VOL_W'(1);
			end else if (out_port == PORT_W'(2) && volume > VOL_MIN) begin
				volume <= volume - VOL_W'(1);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Input port mux, one cycle behind port_id
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			in_port <= '0;
		end else begin
			case (port_id)
				PORT_SELECT: in_port <= PORT_W'(select);
				PORT_BACK: in_port <= PORT_W'(back);
				PORT_PAUSE: in_port <= PORT_W'(pause_play);
				PORT_MSG_EXISTS: in_port <= PORT_W'(menu.message_exists);
				PORT_DEL_DONE: in_port <= PORT_W'(menu.delete_finish);
				// Unmapped reads as zero
				default: in_port <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/address_walker.sv */
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Slot address walker
////////////////////////////////////////////////////////////////////////////

module address_walker import recorder_pkg::*; (
	input wire clk2,
	input wire pb_reset,
	input wire [ADDR_W-1:0] max_ram_address,
	walker_if.walker walk
);

	// Slot window from the slot map
	logic [ADDR_W-1:0] slot_base;
	logic [ADDR_W-1:0] slot_limit;
	// Limit of the walk in progress
	logic [ADDR_W-1:0] limit;

	// Base is slot index times slot size
	assign slot_base = ADDR_W'(walk.slot) * SLOT_WORDS;

	// Top slot ends at the memory size, others one word short of the next base
	assign slot_limit = (walk.slot == LAST_SLOT) ? max_ram_address :
		slot_base + SLOT_WORDS - ADDR_W'(1);

	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			walk.address <= '0;
			limit <= '0;
		end else if (walk.load_all) begin
			// Whole memory
			walk.address <= '0;
			limit <= max_ram_address;
		end else if (walk.load_slot) begin
			walk.address <= slot_base;
			limit <= slot_limit;
		end else if (walk.step) begin
			walk.address <= walk.address + ADDR_W'(1);
		end
	end

	// End of walk flag
	assign walk.last = (walk.address >= limit);

endmodule

`default_nettype wire

/* src/message_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Play, record and delete sequencer
////////////////////////////////////////////////////////////////////////////

module message_sequencer import recorder_pkg::*; (
	input wire clk2,
	input wire pb_reset,
	input wire [DATA_W-1:0] audio_in,
	input wire [DATA_W-1:0] ram_rdata,
	input wire ram_data_present,
	output logic playback,
	output logic [DATA_W-1:0] audio_out,
	output logic [DATA_W-1:0] ram_wdata,
	output logic ram_write_enable,
	output logic ram_read_request,
	output logic ram_read_ack,
	menu_if.seq menu,
	walker_if.seq walk
);

	seq_state_e state;

	// One operation per menu entry
	logic op_spent;
	// Mode write seen while busy
	logic abort_req;
	logic abort;

	// Start requests from idle
	logic start_play;
	logic start_record;
	logic start_del_one;
	logic start_del_all;
	// Read word arriving this cycle
	logic capture;

	assign start_play = menu.mode == MODE_PLAY && menu.slot_valid && !op_spent;
	assign start_record = menu.mode == MODE_RECORD && menu.slot_valid
		&& menu.record_armed && !op_spent;
	assign start_del_one = menu.mode == MODE_DELETE_ONE && menu.slot_valid && !op_spent;
	// Delete all fires on entry to the mode
	assign start_del_all = menu.mode == MODE_DELETE_ALL && menu.mode_write;

	assign abort = abort_req || menu.mode_write;
	assign capture = ram_data_present && (state == ST_PLAY_FETCH || state == ST_RECORD_PROBE);

	// Walker control
	assign walk.slot = menu.slot;
	assign walk.load_slot = (state == ST_IDLE) && (start_play || start_record || start_del_one);
	assign walk.load_all = (state == ST_IDLE) && start_del_all;

	always_comb begin
		case (state)
			ST_PLAY_STEP, ST_RECORD_STEP: walk.step = !walk.last && !abort;
			// Deletion ignores aborts
			ST_DELETE_STEP: walk.step = !walk.last;
			default: walk.step = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk2 or posedge pb_reset) begin
		if (pb_reset) begin
			state <= ST_IDLE;
			playback <= 1'b0;
			menu.message_exists <= 1'b0;
			menu.delete_finish <= 1'b0;
			ram_write_enable <= 1'b0;
			ram_read_request <= 1'b0;
			ram_read_ack <= 1'b0;
			op_spent <= 1'b0;
			abort_req <= 1'b0;
		end else begin
			// Memory strobes are single cycle
			ram_write_enable <= 1'b0;
			ram_read_request <= 1'b0;
			ram_read_ack <= 1'b0;
			if (state == ST_IDLE) begin
				abort_req <= 1'b0;
			end else if (menu.mode_write) begin
				abort_req <= 1'b1;
			end
			if (menu.mode_write) begin
				op_spent <= 1'b0;
			end
			case (state)
				ST_IDLE: begin
					if (start_play) begin
						playback <= 1'b1;
						op_spent <= 1'b1;
						state <= ST_PLAY_WAIT;
					end else if (start_record) begin
						menu.message_exists <= 1'b0;
						op_spent <= 1'b1;
						state <= ST_RECORD_CHECK;
					end else if (start_del_one || start_del_all) begin
						menu.delete_finish <= 1'b0;
						op_spent <= 1'b1;
						state <= ST_DELETE_WRITE;
					end
				end
				// Playback loop
				ST_PLAY_WAIT: begin
					if (abort) begin
						playback <= 1'b0;
						state <= ST_IDLE;
					end else begin
						ram_read_request <= 1'b1;
						state <= ST_PLAY_REQUEST;
					end
				end
				ST_PLAY_REQUEST: state <= ST_PLAY_FETCH;
				ST_PLAY_FETCH: begin
					if (ram_data_present) begin
						ram_read_ack <= 1'b1;
						state <= ST_PLAY_STEP;
					end
				end
				ST_PLAY_STEP: begin
					if (walk.last || abort) begin
						playback <= 1'b0;
						state <= ST_IDLE;
					end else begin
						state <= ST_PLAY_WAIT;
					end
				end
				// Probe first word of the slot
				ST_RECORD_CHECK: begin
					if (abort) begin
						state <= ST_IDLE;
					end else begin
						ram_read_request <= 1'b1;
						state <= ST_RECORD_PROBE;
					end
				end
				ST_RECORD_PROBE: begin
					if (ram_data_present) begin
						ram_read_ack <= 1'b1;
						// Occupied slot is left alone
						if (ram_rdata != '0) begin
							menu.message_exists <= 1'b1;
							state <= ST_IDLE;
						end else begin
							state <= ST_RECORD_WRITE;
						end
					end
				end
				ST_RECORD_WRITE: begin
					ram_write_enable <= 1'b1;
					state <= ST_RECORD_STEP;
				end
				ST_RECORD_STEP: begin
					if (walk.last || abort) begin
						state <= ST_IDLE;
					end else begin
						state <= ST_RECORD_WRITE;
					end
				end
				// Zero fill up to the limit
				ST_DELETE_WRITE: begin
					ram_write_enable <= 1'b1;
					state <= ST_DELETE_STEP;
				end
				ST_DELETE_STEP: begin
					if (walk.last) begin
						menu.delete_finish <= 1'b1;
						state <= ST_IDLE;
					end else begin
						state <= ST_DELETE_WRITE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Data path registers
	always_ff @(posedge clk2) begin
		if (capture) begin
			audio_out <= ram_rdata;
		end
		if (state == ST_RECORD_WRITE) begin
			ram_wdata <= audio_in;
		end else if (state == ST_DELETE_WRITE) begin
			ram_wdata <= '0;
		end
	end

endmodule

`default_nettype wire

/* src/recorder_controller.sv */
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Voice recorder message controller top
////////////////////////////////////////////////////////////////////////////

module recorder_controller import recorder_pkg::*; (
	input wire clk2,
	input wire pb_reset,
	// Processor port bus
	input wire [PORT_W-1:0] port_id,
	input wire [PORT_W-1:0] out_port,
	input wire write_strobe,
	// No read side effects remain on the port bus
	input wire read_strobe,
	output wire [PORT_W-1:0] in_port,
	// Buttons
	input wire select,
	input wire back,
	input wire pause_play,
	// Audio side
	output wire [VOL_W-1:0] volume,
	output wire playback,
	input wire [DATA_W-1:0] audio_in,
	output wire [DATA_W-1:0] audio_out,
	// Word memory
	input wire [ADDR_W-1:0] max_ram_address,
	output wire [ADDR_W-1:0] ram_address,
	output wire [DATA_W-1:0] ram_wdata,
	output wire ram_write_enable,
	output wire ram_read_request,
	output wire ram_read_ack,
	input wire [DATA_W-1:0] ram_rdata,
	input wire ram_data_present
);

	menu_if menu_bus ();
	walker_if walk_bus ();

	// Port decode and menu state
	pb_port_regs regs_i (
		.clk2(clk2),
		.pb_reset(pb_reset),
		.port_id(port_id),
		.out_port(out_port),
		.write_strobe(write_strobe),
		.select(select),
		.back(back),
		.pause_play(pause_play),
		.in_port(in_port),
		.volume(volume),
		.menu(menu_bus.regs)
	);

	message_sequencer seq_i (
		.clk2(clk2),
		.pb_reset(pb_reset),
		.audio_in(audio_in),
		.ram_rdata(ram_rdata),
		.ram_data_present(ram_data_present),
		.playback(playback),
		.audio_out(audio_out),
		.ram_wdata(ram_wdata),
		.ram_write_enable(ram_write_enable),
		.ram_read_request(ram_read_request),
		.ram_read_ack(ram_read_ack),
		.menu(menu_bus.seq),
		.walk(walk_bus.seq)
	);

	address_walker walker_i (
		.clk2(clk2),
		.pb_reset(pb_reset),
		.max_ram_address(max_ram_address),
		.walk(walk_bus.walker)
	);

	// Memory address straight from the walker
	assign ram_address = walk_bus.address;

endmodule

`default_nettype wire

/* verification/recorder_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Protocol checks on the recorder top level
////////////////////////////////////////////////////////////////////////////

module recorder_assertions import recorder_pkg::*; (
	input wire clk2,
	input wire pb_reset,
	input wire [VOL_W-1:0] volume,
	input wire [DATA_W-1:0] audio_out,
	input wire [ADDR_W-1:0] ram_address,
	input wire ram_write_enable,
	input wire ram_read_ack,
	input wire [DATA_W-1:0] ram_rdata,
	input wire ram_data_present
);

	// Failed assertion count, read by the testbench at the end
	int fail_count = 0;

	// Ack strobe is one cycle wide
	ack_one_cycle: assert property (@(posedge clk2) disable iff (pb_reset)
		ram_read_ack |=> !ram_read_ack)
	else begin
		fail_count++;
		$error("ram_read_ack high for more than one cycle");
	end

	// Ack only after the memory showed data
	ack_after_data: assert property (@(posedge clk2) disable iff (pb_reset)
		ram_read_ack |-> $past(ram_data_present))
	else begin
		fail_count++;
		$error("ram_read_ack without ram_data_present in the cycle before");
	end

	// Word on audio_out is the one the memory presented
	ack_word: assert property (@(posedge clk2) disable iff (pb_reset)
		ram_read_ack |-> audio_out == $past(ram_rdata))
	else begin
		fail_count++;
		$error("audio_out differs from ram_rdata of the cycle before the ack");
	end

	// Four bits cap it at 15, so only zero is out of range
	volume_range: assert property (@(posedge clk2) disable iff (pb_reset)
		volume != '0)
	else begin
		fail_count++;
		$error("volume left the range 1 to 15");
	end

	volume_step: assert property (@(posedge clk2) disable iff (pb_reset)
		volume == $past(volume) || volume == $past(volume) + VOL_W'(1)
			|| volume == $past(volume) - VOL_W'(1))
	else begin
		fail_count++;
		$error("volume moved by more than one step");
	end

	// Walk writes come every second cycle at rising addresses
	walk_address: assert property (@(posedge clk2) disable iff (pb_reset)
		ram_write_enable && $past(ram_write_enable, 2)
			|-> ram_address == $past(ram_address, 2) + ADDR_W'(1))
	else begin
		fail_count++;
		$error("walk write not at the next address");
	end

endmodule

bind recorder_controller recorder_assertions assertions_i (
	.clk2(clk2),
	.pb_reset(pb_reset),
	.volume(volume),
	.audio_out(audio_out),
	.ram_address(ram_address),
	.ram_write_enable(ram_write_enable),
	.ram_read_ack(ram_read_ack),
	.ram_rdata(ram_rdata),
	.ram_data_present(ram_data_present)
);

`default_nettype wire

/* verification/tb_recorder.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_recorder import recorder_pkg::*; ();

	// Walk sizes kept short
	localparam int ALL_LIMIT = 31;
	localparam int SLOT4_WORDS = 13;
	// Slot 4 starts at 4 x 0x333333
	localparam logic [ADDR_W-1:0] SLOT4_BASE = 26'hCCCCCC;
	localparam logic [ADDR_W-1:0] SLOT4_LIMIT = SLOT4_BASE + 26'd12;
	localparam int TIMEOUT = 2000;
	// Quiet window to catch writes past the limit
	localparam int SETTLE = 12;

	logic clk2;
	logic pb_reset;
	logic [PORT_W-1:0] port_id;
	logic [PORT_W-1:0] out_port;
	logic write_strobe;
	logic read_strobe;
	logic select;
	logic back;
	logic pause_play;
	logic [ADDR_W-1:0] max_ram_address;
	// Driven by the memory model
	logic [DATA_W-1:0] audio_in = '0;
	logic [DATA_W-1:0] ram_rdata = '0;
	logic ram_data_present = 1'b0;

	wire [PORT_W-1:0] in_port;
	wire [VOL_W-1:0] volume;
	wire playback;
	wire [DATA_W-1:0] audio_out;
	wire [ADDR_W-1:0] ram_address;
	wire [DATA_W-1:0] ram_wdata;
	wire ram_write_enable;
	wire ram_read_request;
	wire ram_read_ack;

	// Sparse word memory and logs
	logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
	logic [ADDR_W-1:0] wr_addr_q[$];
	logic [DATA_W-1:0] wr_data_q[$];
	logic [DATA_W-1:0] audio_q[$];
	logic [DATA_W-1:0] ack_q[$];
	logic [ADDR_W-1:0] read_addr;
	logic [DATA_W-1:0] sample;
	int read_wait;
	bit read_busy;
	int fill_addr;

	int value_errors;
	int timeouts;
	bit ok;
	// First driven sample of the slot 4 recording
	int rec_mark;

	recorder_controller dut_i (
		.clk2(clk2),
		.pb_reset(pb_reset),
		.port_id(port_id),
		.out_port(out_port),
		.write_strobe(write_strobe),
		.read_strobe(read_strobe),
		.in_port(in_port),
		.select(select),
		.back(back),
		.pause_play(pause_play),
		.volume(volume),
		.playback(playback),
		.audio_in(audio_in),
		.audio_out(audio_out),
		.max_ram_address(max_ram_address),
		.ram_address(ram_address),
		.ram_wdata(ram_wdata),
		.ram_write_enable(ram_write_enable),
		.ram_read_request(ram_read_request),
		.ram_read_ack(ram_read_ack),
		.ram_rdata(ram_rdata),
		.ram_data_present(ram_data_present)
	);

	initial begin
		clk2 = 1'b0;
		forever #10 clk2 = ~clk2;
	end

	// Non-zero fold of the whole address
	function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
		return (a[15:0] ^ {6'd0, a[25:16]} ^ 16'h5A3C) | 16'h8000;
	endfunction

	function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] a);
		return mem.exists(a) ? mem[a] : '0;
	endfunction

	// Audio samples are never zero
	function automatic logic [DATA_W-1:0] next_sample();
		logic [DATA_W-1:0] s;
		s = DATA_W'($urandom());
		if (s == '0) begin
			s = 16'h0001;
		end
		return s;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Memory model with random read latency
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clk2) begin
		if (pb_reset) begin
			ram_data_present <= 1'b0;
			read_busy = 1'b0;
			// Old contents in the low words
			for (fill_addr = 0; fill_addr <= ALL_LIMIT; fill_addr++) begin
				mem[ADDR_W'(fill_addr)] = fill_word(ADDR_W'(fill_addr));
			end
			if (audio_q.size() == 0) begin
				sample = next_sample();
				audio_in <= sample;
				audio_q.push_back(sample);
			end
		end else begin
			if (ram_write_enable) begin
				mem[ram_address] = ram_wdata;
				wr_addr_q.push_back(ram_address);
				wr_data_q.push_back(ram_wdata);
				// Fresh sample for the next word
				sample = next_sample();
				audio_in <= sample;
				audio_q.push_back(sample);
			end
			if (ram_read_ack) begin
				ram_data_present <= 1'b0;
				ack_q.push_back(audio_out);
			end
			if (ram_read_request) begin
				read_addr = ram_address;
				read_wait = $urandom_range(4, 1);
				read_busy = 1'b1;
			end else if (read_busy) begin
				read_wait--;
				if (read_wait == 0) begin
					ram_rdata <= read_word(read_addr);
					ram_data_present <= 1'b1;
					read_busy = 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks and waits
	////////////////////////////////////////////////////////////////////////////
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			value_errors++;
			$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		ok = 1'b0;
		$display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
	endtask

	task automatic wait_writes(input int mark, input int count, input string what);
		int cycles;
		cycles = 0;
		while (wr_addr_q.size() - mark < count && ok) begin
			@(negedge clk2);
			cycles++;
			if (cycles > TIMEOUT) report_timeout(what);
		end
	endtask

	task automatic wait_acks(input int mark, input int count, input string what);
		int cycles;
		cycles = 0;
		while (ack_q.size() - mark < count && ok) begin
			@(negedge clk2);
			cycles++;
			if (cycles > TIMEOUT) report_timeout(what);
		end
	endtask

	task automatic wait_playback(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (playback !== level && ok) begin
			@(negedge clk2);
			cycles++;
			if (cycles > TIMEOUT) report_timeout(what);
		end
	endtask

	// Single cycle write strobe
	task automatic write_port(input logic [PORT_W-1:0] id, input logic [PORT_W-1:0] value);
		@(posedge clk2);
		port_id <= id;
		out_port <= value;
		write_strobe <= 1'b1;
		@(posedge clk2);
		write_strobe <= 1'b0;
	endtask

	// in_port follows port_id one cycle later
	task automatic read_port(input logic [PORT_W-1:0] id, output logic [PORT_W-1:0] value);
		@(posedge clk2);
		port_id <= id;
		@(posedge clk2);
		@(negedge clk2);
		value = in_port;
	endtask

	task automatic expect_port(input logic [PORT_W-1:0] id, input logic [PORT_W-1:0] expected,
			input string name);
		logic [PORT_W-1:0] value;
		read_port(id, value);
		check_value(name, 32'(expected), 32'(value));
	endtask

	// Poll a status bit until it reads 1
	task automatic wait_port_set(input logic [PORT_W-1:0] id, input string what);
		int cycles;
		cycles = 0;
		@(posedge clk2);
		port_id <= id;
		@(posedge clk2);
		@(negedge clk2);
		while (in_port[0] !== 1'b1 && ok) begin
			@(negedge clk2);
			cycles++;
			if (cycles > TIMEOUT) report_timeout(what);
		end
	endtask

	// Walk of slot 4 against the driven samples from mark on
	task automatic check_slot4_record(input int wmark, input int amark);
		int i;
		// Any write past the limit would land in this window
		repeat (SETTLE) @(negedge clk2);
		check_value("record write count", SLOT4_WORDS, wr_addr_q.size() - wmark);
		for (i = 0; i < SLOT4_WORDS; i++) begin
			check_value("ram_address", 32'(SLOT4_BASE + ADDR_W'(i)), 32'(wr_addr_q[wmark + i]));
			check_value("ram_wdata", 32'(audio_q[amark + i]), 32'(wr_data_q[wmark + i]));
			check_value("mem", 32'(audio_q[amark + i]), 32'(read_word(SLOT4_BASE + ADDR_W'(i))));
		end
		check_value("mem past limit", 0, 32'(read_word(SLOT4_LIMIT + 26'd1)));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////
	task automatic check_reset_state();
		@(negedge clk2);
		check_value("ram_write_enable", 0, 32'(ram_write_enable));
		check_value("ram_read_request", 0, 32'(ram_read_request));
		check_value("ram_read_ack", 0, 32'(ram_read_ack));
		check_value("playback", 0, 32'(playback));
		check_value("volume", 1, 32'(volume));
		check_value("in_port", 0, 32'(in_port));
		expect_port(PORT_VOLUME, 8'h00, "in_port at volume port");
		expect_port(8'h3C, 8'h00, "in_port at unmapped port");
		expect_port(PORT_MSG_EXISTS, 8'h00, "in_port at message exists port");
		expect_port(PORT_DEL_DONE, 8'h00, "in_port at delete done port");
	endtask

	task automatic test_volume();
		write_port(PORT_MODE, PORT_W'(MODE_VOLUME));
		repeat (20) write_port(PORT_VOLUME, 8'd1);
		@(negedge clk2);
		check_value("volume", 15, 32'(volume));
		repeat (20) write_port(PORT_VOLUME, 8'd2);
		@(negedge clk2);
		check_value("volume", 1, 32'(volume));
		// Ignored outside volume mode
		write_port(PORT_MODE, PORT_W'(MODE_MAIN));
		repeat (3) write_port(PORT_VOLUME, 8'd1);
		@(negedge clk2);
		check_value("volume", 1, 32'(volume));
	endtask

	task automatic test_delete_all();
		int mark;
		int i;
		mark = wr_addr_q.size();
		write_port(PORT_MODE, PORT_W'(MODE_DELETE_ALL));
		wait_writes(mark, ALL_LIMIT + 1, "delete-all writes");
		wait_port_set(PORT_DEL_DONE, "delete-all done flag");
		if (!ok) return;
		check_value("delete-all write count", ALL_LIMIT + 1, wr_addr_q.size() - mark);
		for (i = 0; i <= ALL_LIMIT; i++) begin
			check_value("ram_address", i, 32'(wr_addr_q[mark + i]));
			check_value("ram_wdata", 0, 32'(wr_data_q[mark + i]));
			check_value("mem", 0, 32'(read_word(ADDR_W'(i))));
		end
	endtask

	task automatic test_record_empty();
		int mark;
		@(posedge clk2);
		max_ram_address <= SLOT4_LIMIT;
		write_port(PORT_MODE, PORT_W'(MODE_RECORD));
		write_port(PORT_RECORD, 8'd6);
		// Idle, so audio_in is the newest sample
		mark = wr_addr_q.size();
		rec_mark = audio_q.size() - 1;
		write_port(PORT_RECORD, 8'd1);
		wait_writes(mark, SLOT4_WORDS, "slot 4 recording");
		if (!ok) return;
		check_slot4_record(mark, rec_mark);
	endtask

	task automatic test_record_occupied();
		int mark;
		mark = wr_addr_q.size();
		write_port(PORT_MODE, PORT_W'(MODE_RECORD));
		write_port(PORT_RECORD, 8'd6);
		write_port(PORT_RECORD, 8'd1);
		wait_port_set(PORT_MSG_EXISTS, "message exists flag");
		if (!ok) return;
		check_value("write count on occupied slot", 0, wr_addr_q.size() - mark);
	endtask

	task automatic test_play();
		int mark;
		int i;
		mark = ack_q.size();
		write_port(PORT_MODE, PORT_W'(MODE_PLAY));
		write_port(PORT_SLOT, 8'd4);
		wait_playback(1'b1, "playback to rise on slot 4");
		wait_playback(1'b0, "playback to fall after slot 4");
		if (!ok) return;
		check_value("play word count", SLOT4_WORDS, ack_q.size() - mark);
		for (i = 0; i < SLOT4_WORDS; i++) begin
			check_value("audio_out", 32'(audio_q[rec_mark + i]), 32'(ack_q[mark + i]));
		end
		// Long slot 0 walk, cut short by a mode write
		mark = ack_q.size();
		write_port(PORT_MODE, PORT_W'(MODE_PLAY));
		write_port(PORT_SLOT, 8'd0);
		wait_playback(1'b1, "playback to rise on slot 0");
		wait_acks(mark, 3, "slot 0 words");
		if (!ok) return;
		write_port(PORT_MODE, PORT_W'(MODE_MAIN));
		wait_playback(1'b0, "playback to fall after abort");
		for (i = 0; i < 3; i++) begin
			check_value("audio_out", 0, 32'(ack_q[mark + i]));
		end
	endtask

	task automatic test_delete_and_rerecord();
		int mark;
		int amark;
		int i;
		mark = wr_addr_q.size();
		write_port(PORT_MODE, PORT_W'(MODE_DELETE_ONE));
		write_port(PORT_SLOT, 8'd4);
		wait_writes(mark, SLOT4_WORDS, "slot 4 delete writes");
		wait_port_set(PORT_DEL_DONE, "delete-one done flag");
		if (!ok) return;
		check_value("delete-one write count", SLOT4_WORDS, wr_addr_q.size() - mark);
		for (i = 0; i < SLOT4_WORDS; i++) begin
			check_value("ram_address", 32'(SLOT4_BASE + ADDR_W'(i)), 32'(wr_addr_q[mark + i]));
			check_value("ram_wdata", 0, 32'(wr_data_q[mark + i]));
		end
		// Probe now finds an empty slot
		write_port(PORT_MODE, PORT_W'(MODE_RECORD));
		write_port(PORT_RECORD, 8'd6);
		mark = wr_addr_q.size();
		amark = audio_q.size() - 1;
		write_port(PORT_RECORD, 8'd1);
		wait_writes(mark, SLOT4_WORDS, "slot 4 second recording");
		if (!ok) return;
		check_slot4_record(mark, amark);
		expect_port(PORT_MSG_EXISTS, 8'h00, "in_port at message exists port");
	endtask

	task automatic finish_run();
		int assert_errors;
		assert_errors = dut_i.assertions_i.fail_count;
		$display("Errors: %0d value, %0d timeout, %0d assertion",
			value_errors, timeouts, assert_errors);
		if (value_errors == 0 && timeouts == 0 && assert_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		void'($urandom(52));
		pb_reset = 1'b1;
		port_id = '0;
		out_port = '0;
		write_strobe = 1'b0;
		read_strobe = 1'b0;
		select = 1'b0;
		back = 1'b0;
		pause_play = 1'b0;
		max_ram_address = ADDR_W'(ALL_LIMIT);
		value_errors = 0;
		timeouts = 0;
		rec_mark = 0;
		ok = 1'b1;
		repeat (4) @(posedge clk2);
		pb_reset <= 1'b0;
		check_reset_state();
		if (ok) test_volume();
		if (ok) test_delete_all();
		if (ok) test_record_empty();
		if (ok) test_record_occupied();
		if (ok) test_play();
		if (ok) test_delete_and_rerecord();
		finish_run();
	end

endmodule

`default_nettype wire

/* src.f */
src/recorder_pkg.sv
src/menu_if.sv
src/walker_if.sv
src/pb_port_regs.sv
src/address_walker.sv
src/message_sequencer.sv
src/recorder_controller.sv
verification/recorder_assertions.sv
verification/tb_recorder.sv

/* run.sh */
#!/usr/bin/env bash
# Build the recorder testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_recorder -f src.f -o sim_recorder \
	|| { echo "Verilator build failed"; exit 1; }

# Assertion errors are counted by the testbench, so let the run continue past them
sim_out="$(./obj_dir/sim_recorder +verilator+error+limit+1000)"
echo "$sim_out"

echo "$sim_out" | grep -qx "Test OK" \
	&& echo "Simulation passed" \
	|| { echo "Simulation did not pass"; exit 1; }
